/* source/chip_select_cfg.svh */
// chip select config, bus widths and decode constants shared by the address maps
`ifndef CHIP_SELECT_CFG_SVH
`define CHIP_SELECT_CFG_SVH

// 68000 address bus, byte address
`define M68K_ADDR_W 24

// z80 memory address bus
`define Z80_ADDR_W 16

// z80 io cycles only decode the low byte
`define Z80_IO_W 8

// start of z80 work ram, everything below is sound rom
`define Z80_RAM_BASE 16'hf800

// one select bit per 68000 window
`define M68K_REGION_N 22

`endif

/* source/board_pkg.sv */
// board package, board type codes and the 68000 select region numbering
`default_nettype none

package board_pkg;

    // codes 3 to 6 are not decoded
    typedef enum logic [2:0] {
        terra_force = 3'd0,
        armedf      = 3'd1,
        legion      = 3'd2,
        bigfghtr    = 3'd7
    } board_t;

    // each value is a bit index into the 68000 select vector
    typedef enum logic [4:0] {
        rom, ram, tile_pal, txt_ram, ram_2, ram_3,
        spr, spr_pal, fg_ram, bg_ram,
        in_p1, in_p2, in_dsw1, in_dsw2,
        irq_z80,
        bg_scroll_x, bg_scroll_y, fg_scroll_x, fg_scroll_y,
        sound_latch, irq_ack, irq_i8751
    } m68k_region_t;

endpackage

`default_nettype wire

/* source/sound_pkg.sv */
// sound package, z80 io port numbers of the sound board
`default_nettype none

package sound_pkg;

    // low address byte during an io cycle
    typedef enum logic [7:0] {
        sound0    = 8'h00, // ym chip 0
        sound1    = 8'h01, // ym chip 1
        dac1      = 8'h02,
        dac2      = 8'h03,
        latch_clr = 8'h04, // clear sound latch
        latch_r   = 8'h06  // read sound latch
    } z80_port_t;

endpackage

`default_nettype wire

/* source/board_latch.sv */
// board latch, samples the board strap while in reset and holds it afterwards
`timescale 1ns/1ns
`default_nettype none

module board_latch (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  logic [2:0]          pcb,
    output board_pkg::board_t   board
);

    import board_pkg::*;

    // follows the strap during reset, frozen once reset is released
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            board <= board_t'(pcb); // unknown codes pass through as is
        end
    end

    // the decode map must not move under a running game
    a_board_held: assert property (
        @(posedge clk_sys) rst_n && $past(rst_n) |-> $stable(board)
    );

endmodule

`default_nettype wire

/* source/m68k_map.sv */
// 68000 map decoding one chip select per region from a per board window table
`timescale 1ns/1ns
`default_nettype none
`include "chip_select_cfg.svh"

module m68k_map (
    input  logic                        clk_sys,
    input  board_pkg::board_t           board,
    input  logic [`M68K_ADDR_W-1:0]     m68k_a,
    input  logic                        m68k_as_n,
    output logic [`M68K_REGION_N-1:0]   m68k_cs
);

    import board_pkg::*;

    // true when a falls inside the window of region r on board b
    // unmapped regions keep lo above hi so nothing ever matches
    function automatic logic hit(board_t b, m68k_region_t r, logic [`M68K_ADDR_W-1:0] a);
        logic [`M68K_ADDR_W-1:0] lo;
        logic [`M68K_ADDR_W-1:0] hi;
        lo = '1;
        hi = '0;
        case (b)
            terra_force: begin
                case (r)
                    rom:         {lo, hi} = {24'h000000, 24'h05ffff};
                    spr:         {lo, hi} = {24'h060000, 24'h0603ff}; // 1k
                    ram:         {lo, hi} = {24'h060400, 24'h063fff};
                    tile_pal:    {lo, hi} = {24'h064000, 24'h064fff};
                    txt_ram:     {lo, hi} = {24'h068000, 24'h069fff};
                    ram_2:       {lo, hi} = {24'h06a000, 24'h06afff};
                    spr_pal:     {lo, hi} = {24'h06c000, 24'h06cfff};
                    fg_ram:      {lo, hi} = {24'h070000, 24'h070fff};
                    bg_ram:      {lo, hi} = {24'h074000, 24'h074fff};
                    in_p1:       {lo, hi} = {24'h078000, 24'h078001};
                    in_p2:       {lo, hi} = {24'h078002, 24'h078003};
                    in_dsw1:     {lo, hi} = {24'h078004, 24'h078005};
                    in_dsw2:     {lo, hi} = {24'h078006, 24'h078007};
                    irq_z80:     {lo, hi} = {24'h07c000, 24'h07c001};
                    bg_scroll_x: {lo, hi} = {24'h07c002, 24'h07c003};
                    bg_scroll_y: {lo, hi} = {24'h07c004, 24'h07c005};
                    sound_latch: {lo, hi} = {24'h07c00a, 24'h07c00b};
                    irq_ack:     {lo, hi} = {24'h07c00e, 24'h07c00f};
                    default: ; // no ram_3, no fg scroll, no mcu
                endcase
            end
            armedf: begin
                case (r)
                    rom:         {lo, hi} = {24'h000000, 24'h05ffff};
                    spr:         {lo, hi} = {24'h060000, 24'h0603ff};
                    ram:         {lo, hi} = {24'h060400, 24'h063fff};
                    ram_2:       {lo, hi} = {24'h064000, 24'h065fff}; // 8k
                    bg_ram:      {lo, hi} = {24'h066000, 24'h066fff};
                    fg_ram:      {lo, hi} = {24'h067000, 24'h067fff};
                    txt_ram:     {lo, hi} = {24'h068000, 24'h069fff};
                    tile_pal:    {lo, hi} = {24'h06a000, 24'h06afff};
                    spr_pal:     {lo, hi} = {24'h06b000, 24'h06bfff};
                    in_p1:       {lo, hi} = {24'h06c000, 24'h06c001};
                    in_p2:       {lo, hi} = {24'h06c002, 24'h06c003};
                    in_dsw1:     {lo, hi} = {24'h06c004, 24'h06c005};
                    in_dsw2:     {lo, hi} = {24'h06c006, 24'h06c007};
                    ram_3:       {lo, hi} = {24'h06c008, 24'h06c7ff}; // starts right after dsw2
                    irq_z80:     {lo, hi} = {24'h06d000, 24'h06d001};
                    bg_scroll_x: {lo, hi} = {24'h06d002, 24'h06d003};
                    bg_scroll_y: {lo, hi} = {24'h06d004, 24'h06d005};
                    fg_scroll_x: {lo, hi} = {24'h06d006, 24'h06d007};
                    fg_scroll_y: {lo, hi} = {24'h06d008, 24'h06d009};
                    sound_latch: {lo, hi} = {24'h06d00a, 24'h06d00b};
                    irq_ack:     {lo, hi} = {24'h06d00e, 24'h06d00f};
                    default: ;
                endcase
            end
            legion: begin
                case (r)
                    rom:         {lo, hi} = {24'h000000, 24'h03ffff}; // half size rom
                    spr:         {lo, hi} = {24'h060000, 24'h060fff};
                    ram:         {lo, hi} = {24'h061000, 24'h063fff};
                    tile_pal:    {lo, hi} = {24'h064000, 24'h064fff};
                    txt_ram:     {lo, hi} = {24'h068000, 24'h069fff};
                    ram_3:       {lo, hi} = {24'h06a000, 24'h06a9ff};
                    spr_pal:     {lo, hi} = {24'h06c000, 24'h06cfff};
                    fg_ram:      {lo, hi} = {24'h070000, 24'h070fff};
                    bg_ram:      {lo, hi} = {24'h074000, 24'h074fff};
                    in_p1:       {lo, hi} = {24'h078000, 24'h078001};
                    in_p2:       {lo, hi} = {24'h078002, 24'h078003};
                    in_dsw1:     {lo, hi} = {24'h078004, 24'h078005};
                    in_dsw2:     {lo, hi} = {24'h078006, 24'h078007};
                    irq_z80:     {lo, hi} = {24'h07c000, 24'h07c001};
                    bg_scroll_x: {lo, hi} = {24'h07c002, 24'h07c003};
                    bg_scroll_y: {lo, hi} = {24'h07c004, 24'h07c005};
                    sound_latch: {lo, hi} = {24'h07c00a, 24'h07c00b};
                    irq_ack:     {lo, hi} = {24'h07c00e, 24'h07c00f};
                    default: ;
                endcase
            end
            bigfghtr: begin
                case (r)
                    rom:         {lo, hi} = {24'h000000, 24'h07ffff};
                    spr:         {lo, hi} = {24'h080000, 24'h0805ff};
                    ram:         {lo, hi} = {24'h080600, 24'h083fff};
                    ram_2:       {lo, hi} = {24'h084000, 24'h085fff};
                    bg_ram:      {lo, hi} = {24'h086000, 24'h086fff};
                    fg_ram:      {lo, hi} = {24'h087000, 24'h087fff};
                    txt_ram:     {lo, hi} = {24'h088000, 24'h089fff};
                    tile_pal:    {lo, hi} = {24'h08a000, 24'h08afff};
                    spr_pal:     {lo, hi} = {24'h08b000, 24'h08bfff};
                    in_p1:       {lo, hi} = {24'h08c000, 24'h08c001};
                    in_p2:       {lo, hi} = {24'h08c002, 24'h08c003};
                    in_dsw1:     {lo, hi} = {24'h08c004, 24'h08c005};
                    in_dsw2:     {lo, hi} = {24'h08c006, 24'h08c007};
                    irq_z80:     {lo, hi} = {24'h08d000, 24'h08d001};
                    bg_scroll_x: {lo, hi} = {24'h08d002, 24'h08d003};
                    bg_scroll_y: {lo, hi} = {24'h08d004, 24'h08d005};
                    fg_scroll_x: {lo, hi} = {24'h08d006, 24'h08d007};
                    fg_scroll_y: {lo, hi} = {24'h08d008, 24'h08d009};
                    sound_latch: {lo, hi} = {24'h08d00a, 24'h08d00b};
                    irq_ack:     {lo, hi} = {24'h08d00e, 24'h08d00f};
                    irq_i8751:   {lo, hi} = {24'h400000, 24'h400001}; // mcu interrupt
                    default: ;
                endcase
            end
            default: ; // unknown board maps nothing
        endcase
        return (a >= lo) && (a <= hi);
    endfunction

    always_comb begin
        for (int i = 0; i < `M68K_REGION_N; i++) begin
            m68k_cs[i] = !m68k_as_n && hit(board, m68k_region_t'(i), m68k_a);
        end
    end

    // the 68000 fetches its reset vector from rom on every known board
    a_vector_rom: assert property (
        @(posedge clk_sys)
            !m68k_as_n && (m68k_a == '0)
            && (board inside {terra_force, armedf, legion, bigfghtr})
            |-> m68k_cs[rom]
    );

    // every board table is free of overlapping windows
    a_single_cs: assert property (
        @(posedge clk_sys) $onehot0(m68k_cs)
    );

endmodule

`default_nettype wire

/* source/z80_map.sv */
// z80 map splitting sound cpu memory into rom and ram and decoding the io port selects
`timescale 1ns/1ns
`default_nettype none
`include "chip_select_cfg.svh"

module z80_map (
    input  logic                    clk_sys,
    input  logic [`Z80_ADDR_W-1:0]  z80_addr,
    input  logic                    MREQ_n,
    input  logic                    IORQ_n,
    output logic                    z80_rom_cs,
    output logic                    z80_ram_cs,
    output logic                    z80_sound0_cs,
    output logic                    z80_sound1_cs,
    output logic                    z80_dac1_cs,
    output logic                    z80_dac2_cs,
    output logic                    z80_latch_clr_cs,
    output logic                    z80_latch_r_cs
);

    import sound_pkg::*;

    logic [`Z80_IO_W-1:0] io_port;
    logic                 io_cycle;

    assign io_port  = z80_addr[`Z80_IO_W-1:0]; // upper byte ignored on io
    assign io_cycle = !IORQ_n;

    assign z80_rom_cs = !MREQ_n && (z80_addr <  `Z80_RAM_BASE);
    assign z80_ram_cs = !MREQ_n && (z80_addr >= `Z80_RAM_BASE);

    assign z80_sound0_cs    = io_cycle && (io_port == sound0);
    assign z80_sound1_cs    = io_cycle && (io_port == sound1);
    assign z80_dac1_cs      = io_cycle && (io_port == dac1);
    assign z80_dac2_cs      = io_cycle && (io_port == dac2);
    assign z80_latch_clr_cs = io_cycle && (io_port == latch_clr);
    assign z80_latch_r_cs   = io_cycle && (io_port == latch_r);

    // only one device drives the sound data bus at a time
    a_one_device: assert property (
        @(posedge clk_sys) $onehot0({z80_rom_cs, z80_ram_cs, z80_sound0_cs, z80_sound1_cs,
                                     z80_dac1_cs, z80_dac2_cs, z80_latch_clr_cs,
                                     z80_latch_r_cs})
    );

endmodule

`default_nettype wire

/* source/chip_select.sv */
// chip select top, board latch feeding the 68000 map next to the z80 map
`timescale 1ns/1ns
`default_nettype none
`include "chip_select_cfg.svh"

module chip_select (
    input  logic                        clk_sys,
    input  logic                        rst_n,
    input  logic [2:0]                  pcb,
    input  logic [`M68K_ADDR_W-1:0]     m68k_a,
    input  logic                        m68k_as_n,
    input  logic [`Z80_ADDR_W-1:0]      z80_addr,
    input  logic                        MREQ_n,
    input  logic                        IORQ_n,
    output logic [`M68K_REGION_N-1:0]   m68k_cs,
    output logic                        z80_rom_cs,
    output logic                        z80_ram_cs,
    output logic                        z80_sound0_cs,
    output logic                        z80_sound1_cs,
    output logic                        z80_dac1_cs,
    output logic                        z80_dac2_cs,
    output logic                        z80_latch_clr_cs,
    output logic                        z80_latch_r_cs
);

    import board_pkg::*;

    board_t board; // held board type

    board_latch board_latch_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .pcb     (pcb),
        .board   (board)
    );

    m68k_map m68k_map_i (
        .clk_sys   (clk_sys),
        .board     (board),
        .m68k_a    (m68k_a),
        .m68k_as_n (m68k_as_n),
        .m68k_cs   (m68k_cs)
    );

    // sound side does not depend on the board
    z80_map z80_map_i (
        .clk_sys          (clk_sys),
        .z80_addr         (z80_addr),
        .MREQ_n           (MREQ_n),
        .IORQ_n           (IORQ_n),
        .z80_rom_cs       (z80_rom_cs),
        .z80_ram_cs       (z80_ram_cs),
        .z80_sound0_cs    (z80_sound0_cs),
        .z80_sound1_cs    (z80_sound1_cs),
        .z80_dac1_cs      (z80_dac1_cs),
        .z80_dac2_cs      (z80_dac2_cs),
        .z80_latch_clr_cs (z80_latch_clr_cs),
        .z80_latch_r_cs   (z80_latch_r_cs)
    );

endmodule

`default_nettype wire

/* verif/map_model.svh */
// map model, reference window tables of the four kept boards and the z80 decode rules
`ifndef MAP_MODEL_SVH
`define MAP_MODEL_SVH

// one entry per mapped window, all four boards in one flat list
board_pkg::board_t      win_board[$];
board_pkg::m68k_region_t win_region[$];
logic [23:0]            win_lo[$];
logic [23:0]            win_hi[$];

task automatic add_window(input board_t b, input m68k_region_t r,
                          input logic [23:0] lo, input logic [23:0] hi);
    win_board.push_back(b);
    win_region.push_back(r);
    win_lo.push_back(lo);
    win_hi.push_back(hi);
endtask

// run of word wide registers on consecutive region numbers
task automatic add_regs(input board_t b, input m68k_region_t first,
                        input logic [23:0] base, input int n);
    logic [23:0] lo;
    for (int k = 0; k < n; k++) begin
        lo = base + 24'(2 * k);
        add_window(b, m68k_region_t'(int'(first) + k), lo, lo + 24'd1);
    end
endtask

// terra_force and legion share the upper half of the map
task automatic add_terra_like(input board_t b);
    add_window(b, tile_pal, 24'h064000, 24'h064fff);
    add_window(b, txt_ram, 24'h068000, 24'h069fff);
    add_window(b, spr_pal, 24'h06c000, 24'h06cfff);
    add_window(b, fg_ram, 24'h070000, 24'h070fff);
    add_window(b, bg_ram, 24'h074000, 24'h074fff);
    add_regs(b, in_p1, 24'h078000, 4);
    add_regs(b, irq_z80, 24'h07c000, 3);
    add_window(b, sound_latch, 24'h07c00a, 24'h07c00b);
    add_window(b, irq_ack, 24'h07c00e, 24'h07c00f);
endtask

// bigfghtr is the armedf layout moved up by 128k
task automatic add_armedf_like(input board_t b, input logic [23:0] off);
    add_window(b, ram_2, 24'h064000 + off, 24'h065fff + off);
    add_window(b, bg_ram, 24'h066000 + off, 24'h066fff + off);
    add_window(b, fg_ram, 24'h067000 + off, 24'h067fff + off);
    add_window(b, txt_ram, 24'h068000 + off, 24'h069fff + off);
    add_window(b, tile_pal, 24'h06a000 + off, 24'h06afff + off);
    add_window(b, spr_pal, 24'h06b000 + off, 24'h06bfff + off);
    add_regs(b, in_p1, 24'h06c000 + off, 4);
    add_regs(b, irq_z80, 24'h06d000 + off, 6); // through sound_latch
    add_window(b, irq_ack, 24'h06d00e + off, 24'h06d00f + off);
endtask

task automatic build_model();
    add_window(terra_force, rom, 24'h000000, 24'h05ffff);
    add_window(terra_force, spr, 24'h060000, 24'h0603ff);
    add_window(terra_force, ram, 24'h060400, 24'h063fff);
    add_window(terra_force, ram_2, 24'h06a000, 24'h06afff);
    add_terra_like(terra_force);
    add_window(legion, rom, 24'h000000, 24'h03ffff);
    add_window(legion, spr, 24'h060000, 24'h060fff);
    add_window(legion, ram, 24'h061000, 24'h063fff);
    add_window(legion, ram_3, 24'h06a000, 24'h06a9ff);
    add_terra_like(legion);
    add_window(armedf, rom, 24'h000000, 24'h05ffff);
    add_window(armedf, spr, 24'h060000, 24'h0603ff);
    add_window(armedf, ram, 24'h060400, 24'h063fff);
    add_window(armedf, ram_3, 24'h06c008, 24'h06c7ff);
    add_armedf_like(armedf, 24'h000000);
    add_window(bigfghtr, rom, 24'h000000, 24'h07ffff);
    add_window(bigfghtr, spr, 24'h080000, 24'h0805ff);
    add_window(bigfghtr, ram, 24'h080600, 24'h083fff);
    add_window(bigfghtr, irq_i8751, 24'h400000, 24'h400001);
    add_armedf_like(bigfghtr, 24'h020000);
endtask

function automatic logic [`M68K_REGION_N-1:0] expected_m68k_cs(
        input board_t b, input logic [23:0] a, input logic as_n);
    logic [`M68K_REGION_N-1:0] exp_cs;
    exp_cs = '0;
    for (int i = 0; i < win_lo.size(); i++) begin
        if (!as_n && win_board[i] == b && a >= win_lo[i] && a <= win_hi[i]) begin
            exp_cs[win_region[i]] = 1'b1;
        end
    end
    return exp_cs;
endfunction

// order is rom, ram, sound0, sound1, dac1, dac2, latch_clr, latch_r
function automatic logic [7:0] expected_z80_cs(
        input logic [15:0] addr, input logic mreq_n, input logic iorq_n);
    logic [7:0] port;
    logic       io;
    port = addr[7:0];
    io   = !iorq_n;
    return {!mreq_n && addr < 16'hf800, !mreq_n && addr >= 16'hf800,
            io && port == sound0, io && port == sound1, io && port == dac1,
            io && port == dac2, io && port == latch_clr, io && port == latch_r};
endfunction

`endif

/* verif/chip_select_tb.sv */
// chip select testbench driving random bus accesses on all boards against the map model
`timescale 1ns/1ns
`default_nettype none
`include "chip_select_cfg.svh"

module chip_select_tb;

    import board_pkg::*;
    import sound_pkg::*;

    `include "map_model.svh"

    localparam int RST_CYCLES = 8;
    localparam int N_MAIN     = 1000;
    localparam int N_SHORT    = 200;
    localparam int N_Z80      = 500;
    localparam int PLANNED    = 4 * (RST_CYCLES + 2 + N_MAIN) + N_SHORT
                              + 2 * (RST_CYCLES + 2 + N_SHORT) + N_Z80;
    localparam int LIMIT      = PLANNED * 3 / 2;

    logic                      clk_sys;
    logic                      rst_n;
    logic [2:0]                pcb;
    logic [`M68K_ADDR_W-1:0]   m68k_a;
    logic                      m68k_as_n;
    logic [`Z80_ADDR_W-1:0]    z80_addr;
    logic                      MREQ_n;
    logic                      IORQ_n;
    logic [`M68K_REGION_N-1:0] m68k_cs;
    logic [7:0]                z80_cs;

    int cycles;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    chip_select chip_select_i (
        .clk_sys          (clk_sys),
        .rst_n            (rst_n),
        .pcb              (pcb),
        .m68k_a           (m68k_a),
        .m68k_as_n        (m68k_as_n),
        .z80_addr         (z80_addr),
        .MREQ_n           (MREQ_n),
        .IORQ_n           (IORQ_n),
        .m68k_cs          (m68k_cs),
        .z80_rom_cs       (z80_cs[7]),
        .z80_ram_cs       (z80_cs[6]),
        .z80_sound0_cs    (z80_cs[5]),
        .z80_sound1_cs    (z80_cs[4]),
        .z80_dac1_cs      (z80_cs[3]),
        .z80_dac2_cs      (z80_cs[2]),
        .z80_latch_clr_cs (z80_cs[1]),
        .z80_latch_r_cs   (z80_cs[0])
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic reset_board(input logic [2:0] strap);
        @(negedge clk_sys);
        rst_n = 1'b0;
        pcb   = strap;
        repeat (RST_CYCLES) @(negedge clk_sys);
        rst_n = 1'b1;
    endtask

    // half the addresses land on a window edge or just outside it
    function automatic logic [23:0] pick_addr();
        int idx;
        idx = $urandom_range(0, win_lo.size() - 1);
        case ($urandom_range(0, 7))
            0: return win_lo[idx];
            1: return win_hi[idx];
            2: return win_lo[idx] - 24'd1;
            3: return win_hi[idx] + 24'd1;
            4, 5: return {4'h0, 20'($urandom)}; // low megabyte holds most windows
            default: return 24'($urandom);
        endcase
    endfunction

    task automatic m68k_access(input board_t b, input logic as_n);
        logic [`M68K_REGION_N-1:0] exp_cs;
        @(negedge clk_sys);
        m68k_a    = pick_addr();
        m68k_as_n = as_n;
        exp_cs    = expected_m68k_cs(b, m68k_a, as_n);
        @(posedge clk_sys);
        if (m68k_cs !== exp_cs) begin
            $display("ERROR %0t m68k_cs a=%h expected %h actual %h",
                     $time, m68k_a, exp_cs, m68k_cs);
            test_errors++;
        end
    endtask

    task automatic z80_access();
        logic [7:0] exp_cs;
        int         kind;
        @(negedge clk_sys);
        kind     = $urandom_range(0, 2);
        z80_addr = $urandom_range(0, 1) ? 16'($urandom) : {8'($urandom), 5'd0, 3'($urandom)};
        if (kind == 0 && $urandom_range(0, 3) == 0) begin
            z80_addr = 16'hf7fe + 16'($urandom_range(0, 3)); // around the ram base
        end
        MREQ_n = (kind != 0);
        IORQ_n = (kind != 1);
        exp_cs = expected_z80_cs(z80_addr, MREQ_n, IORQ_n);
        @(posedge clk_sys);
        if (z80_cs !== exp_cs) begin
            $display("ERROR %0t z80_cs addr=%h expected %b actual %b",
                     $time, z80_addr, exp_cs, z80_cs);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail, %0d mismatches", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        board_t boards[4];
        boards = '{terra_force, armedf, legion, bigfghtr};
        rst_n     = 1'b0;
        pcb       = 3'd0;
        m68k_a    = '0;
        m68k_as_n = 1'b1;
        z80_addr  = '0;
        MREQ_n    = 1'b1;
        IORQ_n    = 1'b1;
        cycles = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(2799));
        build_model();

        foreach (boards[i]) begin
            reset_board(boards[i]);
            repeat (N_MAIN) m68k_access(boards[i], 1'b0);
            end_test($sformatf("map %s", boards[i].name()));
        end

        // strobe high on the last board
        repeat (N_SHORT) m68k_access(bigfghtr, 1'b1);
        end_test("idle strobe");

        reset_board(3'd3);
        repeat (N_SHORT) m68k_access(board_t'(3'd3), 1'b0);
        end_test("unknown board");

        reset_board(legion);
        pcb = armedf; // strap moves after reset
        repeat (N_SHORT) m68k_access(legion, 1'b0);
        end_test("board held");

        repeat (N_Z80) z80_access();
        end_test("z80 map");

        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
+incdir+verif
source/board_pkg.sv
source/sound_pkg.sv
source/board_latch.sv
source/m68k_map.sv
source/z80_map.sv
source/chip_select.sv
verif/chip_select_tb.sv

/* run.sh */
#!/usr/bin/env bash
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module chip_select_tb \
    -o chip_select_sim \
    && ./obj_dir/chip_select_sim > sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
